// File: include/blend_cfg.svh
`ifndef BLEND_CFG_SVH
`define BLEND_CFG_SVH

// width of one colour or alpha channel.
`define BLEND_CHANNEL_BITS 8

// pixel number width, covers 640 x 480 = 307200 pixels.
`define BLEND_PIXEL_BITS 19

// full-scale alpha, also the blend divisor.
`define BLEND_ALPHA_MAX 255

// edges from the edge that samples read to valid read data.
// the fetch stage works with 1 or 2.
`define BLEND_READ_LATENCY 1

`endif

// File: logic/blend_pkg.sv
`default_nettype none

`include "blend_cfg.svh"

package blend_pkg;

	// one colour channel.
	typedef logic [`BLEND_CHANNEL_BITS-1:0] channel_t;

	// opacity, full scale is an opaque foreground.
	typedef logic [`BLEND_CHANNEL_BITS-1:0] alpha_t;

	// frame memory address, one word per pixel.
	typedef logic [`BLEND_PIXEL_BITS-1:0] pixel_index_t;

	// fg * a + bg * (max - a), at most 255 * 255 = 65025.
	typedef logic [2*`BLEND_CHANNEL_BITS-1:0] weight_sum_t;

endpackage

`default_nettype wire

// File: logic/pixel_fetch.sv
`timescale 1ns/10ps
`default_nettype none

`include "blend_cfg.svh"

module pixel_fetch
(
	input logic clk,
	input logic rst,
	input logic pixel_ready,
	input blend_pkg::pixel_index_t pixel_number,
	input blend_pkg::channel_t r,
	input blend_pkg::channel_t g,
	input blend_pkg::channel_t b,
	input blend_pkg::alpha_t a,
	input logic frame_ready,
	output logic read,
	output blend_pkg::pixel_index_t read_address,
	output logic fetch_valid,
	output blend_pkg::pixel_index_t fetch_index,
	output blend_pkg::channel_t fetch_r,
	output blend_pkg::channel_t fetch_g,
	output blend_pkg::channel_t fetch_b,
	output blend_pkg::alpha_t fetch_a,
	output logic fetch_mark
);
	import blend_pkg::*;

	localparam int LATENCY = `BLEND_READ_LATENCY;

	logic req_valid; // doubles as the read strobe.
	logic req_mark;
	pixel_index_t req_index;
	channel_t req_r;
	channel_t req_g;
	channel_t req_b;
	alpha_t req_a;

	// foreground waits here until memory returns the background.
	logic dly_valid [LATENCY];
	logic dly_mark [LATENCY];
	pixel_index_t dly_index [LATENCY];
	channel_t dly_r [LATENCY];
	channel_t dly_g [LATENCY];
	channel_t dly_b [LATENCY];
	alpha_t dly_a [LATENCY];

	// strobes and marks.
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			req_valid <= 1'b0;
			req_mark <= 1'b0;
			for (int i = 0; i < LATENCY; i++)
			begin
				dly_valid[i] <= 1'b0;
				dly_mark[i] <= 1'b0;
			end
		end
		else
		begin
			req_valid <= pixel_ready;
			req_mark <= frame_ready; // mark rides along even without a pixel.
			dly_valid[0] <= req_valid;
			dly_mark[0] <= req_mark;
			for (int i = 1; i < LATENCY; i++)
			begin
				dly_valid[i] <= dly_valid[i-1];
				dly_mark[i] <= dly_mark[i-1];
			end
		end
	end

	// pixel payload.
	always_ff @(posedge clk)
	begin
		req_index <= pixel_number;
		req_r <= r;
		req_g <= g;
		req_b <= b;
		req_a <= a;
		dly_index[0] <= req_index;
		dly_r[0] <= req_r;
		dly_g[0] <= req_g;
		dly_b[0] <= req_b;
		dly_a[0] <= req_a;
		for (int i = 1; i < LATENCY; i++)
		begin
			dly_index[i] <= dly_index[i-1];
			dly_r[i] <= dly_r[i-1];
			dly_g[i] <= dly_g[i-1];
			dly_b[i] <= dly_b[i-1];
			dly_a[i] <= dly_a[i-1];
		end
	end

	assign read = req_valid;
	assign read_address = req_index;

	// last entry lines up with read_r/g/b.
	assign fetch_valid = dly_valid[LATENCY-1];
	assign fetch_mark = dly_mark[LATENCY-1];
	assign fetch_index = dly_index[LATENCY-1];
	assign fetch_r = dly_r[LATENCY-1];
	assign fetch_g = dly_g[LATENCY-1];
	assign fetch_b = dly_b[LATENCY-1];
	assign fetch_a = dly_a[LATENCY-1];

endmodule

`default_nettype wire

// File: logic/alpha_weight.sv
`timescale 1ns/10ps
`default_nettype none

`include "blend_cfg.svh"

module alpha_weight
(
	input logic clk,
	input logic rst,
	input logic fetch_valid,
	input blend_pkg::pixel_index_t fetch_index,
	input blend_pkg::channel_t fetch_r,
	input blend_pkg::channel_t fetch_g,
	input blend_pkg::channel_t fetch_b,
	input blend_pkg::alpha_t fetch_a,
	input logic fetch_mark,
	input blend_pkg::channel_t read_r,
	input blend_pkg::channel_t read_g,
	input blend_pkg::channel_t read_b,
	output logic weight_valid,
	output blend_pkg::pixel_index_t weight_index,
	output blend_pkg::weight_sum_t sum_r,
	output blend_pkg::weight_sum_t sum_g,
	output blend_pkg::weight_sum_t sum_b,
	output logic weight_mark
);
	import blend_pkg::*;

	alpha_t inv_a;
	weight_sum_t next_r;
	weight_sum_t next_g;
	weight_sum_t next_b;

	// fg * alpha + bg * (max - alpha), cannot overflow the sum type.
	function automatic weight_sum_t weigh
	(
		input channel_t fg,
		input channel_t bg,
		input alpha_t alpha,
		input alpha_t inv
	);
		weight_sum_t fg_part;
		weight_sum_t bg_part;
		fg_part = weight_sum_t'(fg) * weight_sum_t'(alpha);
		bg_part = weight_sum_t'(bg) * weight_sum_t'(inv);
		return fg_part + bg_part;
	endfunction

	// shared by all three channels.
	assign inv_a = alpha_t'(`BLEND_ALPHA_MAX) - fetch_a;

	assign next_r = weigh(fetch_r, read_r, fetch_a, inv_a);
	assign next_g = weigh(fetch_g, read_g, fetch_a, inv_a);
	assign next_b = weigh(fetch_b, read_b, fetch_a, inv_a);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			weight_valid <= 1'b0;
			weight_mark <= 1'b0;
		end
		else
		begin
			weight_valid <= fetch_valid;
			weight_mark <= fetch_mark;
		end
	end

	// sums are only looked at when weight_valid is set.
	always_ff @(posedge clk)
	begin
		weight_index <= fetch_index;
		sum_r <= next_r;
		sum_g <= next_g;
		sum_b <= next_b;
	end

endmodule

`default_nettype wire

// File: logic/norm_divide.sv
`timescale 1ns/10ps
`default_nettype none

`include "blend_cfg.svh"

module norm_divide
(
	input logic clk,
	input logic rst,
	input logic weight_valid,
	input blend_pkg::pixel_index_t weight_index,
	input blend_pkg::weight_sum_t sum_r,
	input blend_pkg::weight_sum_t sum_g,
	input blend_pkg::weight_sum_t sum_b,
	input logic weight_mark,
	output logic write,
	output blend_pkg::pixel_index_t write_address,
	output blend_pkg::channel_t write_r,
	output blend_pkg::channel_t write_g,
	output blend_pkg::channel_t write_b,
	output logic o_frame_ready
);
	import blend_pkg::*;

	localparam int CB = `BLEND_CHANNEL_BITS;

	channel_t quot_r;
	channel_t quot_g;
	channel_t quot_b;

	// floor(x / 255) as (x + (x >> 8) + 1) >> 8.
	// exact for every x below 65535, so the whole sum range is covered.
	function automatic channel_t div_max(input weight_sum_t sum);
		logic [2*CB:0] wide; // one spare bit for the carry.
		weight_sum_t hi;
		hi = sum >> CB;
		wide = {1'b0, sum} + {1'b0, hi} + 1'b1;
		return wide[2*CB-1:CB];
	endfunction

	assign quot_r = div_max(sum_r);
	assign quot_g = div_max(sum_g);
	assign quot_b = div_max(sum_b);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			write <= 1'b0;
			o_frame_ready <= 1'b0;
		end
		else
		begin
			write <= weight_valid;
			o_frame_ready <= weight_mark; // lands with the last pixel's write.
		end
	end

	always_ff @(posedge clk)
	begin
		write_address <= weight_index;
		write_r <= quot_r;
		write_g <= quot_g;
		write_b <= quot_b;
	end

endmodule

`default_nettype wire

// File: logic/alpha_blender.sv
`timescale 1ns/10ps
`default_nettype none

module alpha_blender
(
	input logic clk,
	input logic rst,
	input logic pixel_ready,
	input blend_pkg::pixel_index_t pixel_number,
	input blend_pkg::channel_t r,
	input blend_pkg::channel_t g,
	input blend_pkg::channel_t b,
	input blend_pkg::alpha_t a,
	input blend_pkg::channel_t read_r,
	input blend_pkg::channel_t read_g,
	input blend_pkg::channel_t read_b,
	input logic frame_ready,
	output logic read,
	output blend_pkg::pixel_index_t read_address,
	output logic write,
	output blend_pkg::pixel_index_t write_address,
	output blend_pkg::channel_t write_r,
	output blend_pkg::channel_t write_g,
	output blend_pkg::channel_t write_b,
	output logic o_frame_ready
);
	import blend_pkg::*;

	// fetch to weight.
	logic fetch_valid;
	logic fetch_mark;
	pixel_index_t fetch_index;
	channel_t fetch_r;
	channel_t fetch_g;
	channel_t fetch_b;
	alpha_t fetch_a;

	// weight to divide.
	logic weight_valid;
	logic weight_mark;
	pixel_index_t weight_index;
	weight_sum_t sum_r;
	weight_sum_t sum_g;
	weight_sum_t sum_b;

	pixel_fetch pixel_fetch_inst
	(
		.clk(clk),
		.rst(rst),
		.pixel_ready(pixel_ready),
		.pixel_number(pixel_number),
		.r(r),
		.g(g),
		.b(b),
		.a(a),
		.frame_ready(frame_ready),
		.read(read),
		.read_address(read_address),
		.fetch_valid(fetch_valid),
		.fetch_index(fetch_index),
		.fetch_r(fetch_r),
		.fetch_g(fetch_g),
		.fetch_b(fetch_b),
		.fetch_a(fetch_a),
		.fetch_mark(fetch_mark)
	);

	// background goes straight from memory into the weighting stage.
	alpha_weight alpha_weight_inst
	(
		.clk(clk),
		.rst(rst),
		.fetch_valid(fetch_valid),
		.fetch_index(fetch_index),
		.fetch_r(fetch_r),
		.fetch_g(fetch_g),
		.fetch_b(fetch_b),
		.fetch_a(fetch_a),
		.fetch_mark(fetch_mark),
		.read_r(read_r),
		.read_g(read_g),
		.read_b(read_b),
		.weight_valid(weight_valid),
		.weight_index(weight_index),
		.sum_r(sum_r),
		.sum_g(sum_g),
		.sum_b(sum_b),
		.weight_mark(weight_mark)
	);

	norm_divide norm_divide_inst
	(
		.clk(clk),
		.rst(rst),
		.weight_valid(weight_valid),
		.weight_index(weight_index),
		.sum_r(sum_r),
		.sum_g(sum_g),
		.sum_b(sum_b),
		.weight_mark(weight_mark),
		.write(write),
		.write_address(write_address),
		.write_r(write_r),
		.write_g(write_g),
		.write_b(write_b),
		.o_frame_ready(o_frame_ready)
	);

endmodule

`default_nettype wire

// File: test/alpha_blender_chk.sv
`timescale 1ns/10ps
`default_nettype none

`include "blend_cfg.svh"

module alpha_blender_chk
(
	input logic clk,
	input logic rst,
	input logic pixel_ready,
	input logic frame_ready,
	input logic read,
	input logic write,
	input logic o_frame_ready
);
	// read register, read latency, weight and write registers.
	localparam int DEPTH = 3 + `BLEND_READ_LATENCY;

	// bit i holds rst from i+1 edges back, all ones until the clock runs.
	logic [DEPTH-1:0] rst_hist = '1;

	always @(posedge clk)
	begin
		rst_hist <= {rst_hist[DEPTH-2:0], rst};
	end

	read_follows_pixel: assert property (@(posedge clk)
		(!rst && !rst_hist[0]) |-> (read == $past(pixel_ready)))
		else $error("read is not pixel_ready delayed by one cycle");

	write_follows_pixel: assert property (@(posedge clk)
		(!rst && rst_hist == '0) |-> (write == $past(pixel_ready, DEPTH)))
		else $error("write is not pixel_ready delayed through the pipeline");

	frame_follows_input: assert property (@(posedge clk)
		(!rst && rst_hist == '0) |-> (o_frame_ready == $past(frame_ready, DEPTH)))
		else $error("o_frame_ready is not frame_ready delayed through the pipeline");

	quiet_after_reset: assert property (@(posedge clk)
		(rst_hist[0] && !rst) |-> (!read && !write && !o_frame_ready))
		else $error("strobe high in the cycle after reset");

endmodule

bind alpha_blender alpha_blender_chk alpha_blender_chk_inst
(
	.clk(clk),
	.rst(rst),
	.pixel_ready(pixel_ready),
	.frame_ready(frame_ready),
	.read(read),
	.write(write),
	.o_frame_ready(o_frame_ready)
);

`default_nettype wire

// File: test/alpha_blender_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "blend_cfg.svh"

module alpha_blender_tb;
	import blend_pkg::*;

	localparam int LAT = `BLEND_READ_LATENCY;
	localparam int DEPTH = 3 + LAT; // read, memory wait, weight and write registers.
	localparam int RAND_PIXELS = 40;
	localparam int STREAM_PIXELS = 64;
	// all test pixels with drain and idle gaps, doubled, plus margin.
	localparam int MAX_CYCLES = 4 * (RAND_PIXELS + STREAM_PIXELS + 40) + 200;

	logic clk = 1'b0;
	logic rst;
	logic pixel_ready;
	logic frame_ready;
	pixel_index_t pixel_number;
	channel_t r;
	channel_t g;
	channel_t b;
	alpha_t a;
	channel_t read_r;
	channel_t read_g;
	channel_t read_b;
	logic read;
	logic write;
	logic o_frame_ready;
	pixel_index_t read_address;
	pixel_index_t write_address;
	channel_t write_r;
	channel_t write_g;
	channel_t write_b;

	logic [23:0] mem [pixel_index_t]; // frame memory, sparse.
	logic [23:0] rd_pipe [LAT] = '{default: '0};
	pixel_index_t exp_addr [$];
	logic [23:0] exp_rgb [$];
	logic exp_mark [$];
	logic [DEPTH-1:0] mark_line = '0; // frame_ready seen at each past edge.
	logic [23:0] stream_want [STREAM_PIXELS];
	int errors = 0;
	int cycle_count = 0;
	logic [31:0] rng_state = 32'hb0e6_494e;

	alpha_blender alpha_blender_inst
	(
		.clk(clk),
		.rst(rst),
		.pixel_ready(pixel_ready),
		.pixel_number(pixel_number),
		.r(r),
		.g(g),
		.b(b),
		.a(a),
		.read_r(read_r),
		.read_g(read_g),
		.read_b(read_b),
		.frame_ready(frame_ready),
		.read(read),
		.read_address(read_address),
		.write(write),
		.write_address(write_address),
		.write_r(write_r),
		.write_g(write_g),
		.write_b(write_b),
		.o_frame_ready(o_frame_ready)
	);

	initial
	begin
		forever #2 clk = ~clk;
	end

	function automatic logic [31:0] next_random();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	// untouched memory, a hash of the whole address.
	function automatic logic [23:0] fill_value(input pixel_index_t addr);
		logic [31:0] h;
		h = {13'd0, addr} * 32'h9e37_79b1;
		return h[31:8];
	endfunction

	function automatic logic [23:0] mem_read(input pixel_index_t addr);
		if (mem.exists(addr))
			return mem[addr];
		return fill_value(addr);
	endfunction

	// floor((fg * a + bg * (255 - a)) / 255).
	function automatic channel_t blend_ref(input channel_t fg, input channel_t bg, input alpha_t al);
		int sum;
		sum = int'(fg) * int'(al) + int'(bg) * (255 - int'(al));
		return channel_t'(sum / 255);
	endfunction

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] want);
		if (got !== want)
		begin
			$display("Mismatch at %0t: %s got %0h expected %0h", $time, name, got, want);
			errors++;
		end
	endtask

	task automatic check_write();
		logic [23:0] want;
		mem[write_address] = {write_r, write_g, write_b};
		if (exp_addr.size() == 0)
		begin
			$display("Unexpected write to pixel %0d at %0t", write_address, $time);
			errors++;
			return;
		end
		want = exp_rgb.pop_front();
		compare("write_address", write_address, exp_addr.pop_front());
		compare("write_r", write_r, want[23:16]);
		compare("write_g", write_g, want[15:8]);
		compare("write_b", write_b, want[7:0]);
		compare("o_frame_ready", o_frame_ready, exp_mark.pop_front());
	endtask

	// memory model and write monitor.
	always @(posedge clk)
	begin
		if (write)
			check_write();
		if (!rst)
			compare("o_frame_ready", o_frame_ready, mark_line[DEPTH-1]);
		mark_line <= rst ? '0 : {mark_line[DEPTH-2:0], frame_ready};
		if (read)
			rd_pipe[0] <= mem_read(read_address);
		for (int i = 1; i < LAT; i++)
			rd_pipe[i] <= rd_pipe[i-1];
	end

	assign read_r = rd_pipe[LAT-1][23:16];
	assign read_g = rd_pipe[LAT-1][15:8];
	assign read_b = rd_pipe[LAT-1][7:0];

	// fg packs r, g, b, a from the top byte down.
	task automatic send_pixel(input pixel_index_t idx, input logic [31:0] fg, input logic mark);
		logic [23:0] bg;
		bg = mem_read(idx);
		@(posedge clk);
		pixel_ready <= 1'b1;
		pixel_number <= idx;
		r <= fg[31:24];
		g <= fg[23:16];
		b <= fg[15:8];
		a <= fg[7:0];
		frame_ready <= mark;
		exp_addr.push_back(idx);
		exp_rgb.push_back({blend_ref(fg[31:24], bg[23:16], fg[7:0]),
			blend_ref(fg[23:16], bg[15:8], fg[7:0]), blend_ref(fg[15:8], bg[7:0], fg[7:0])});
		exp_mark.push_back(mark);
	endtask

	task automatic idle(input int n);
		repeat (n)
		begin
			@(posedge clk);
			pixel_ready <= 1'b0;
			frame_ready <= 1'b0;
		end
	endtask

	task automatic drain();
		idle(1);
		while (exp_addr.size() != 0)
			idle(1);
		idle(2);
	endtask

	task automatic alpha_extremes();
		for (int i = 0; i < 4; i++)
			send_pixel(10 + i, {next_random()} | 32'hff, 1'b0); // opaque.
		for (int i = 0; i < 4; i++)
			send_pixel(20 + i, next_random() & 32'hffff_ff00, 1'b0); // transparent.
		drain();
		for (int i = 0; i < 4; i++)
			compare("background", mem_read(20 + i), fill_value(20 + i));
	endtask

	task automatic random_alpha();
		mem[100] = 24'hfe_fe_fe;
		mem[101] = 24'h00_00_00;
		send_pixel(100, 32'hffff_fffe, 1'b0); // sum 65024, remainder 254.
		send_pixel(101, 32'hfefe_fe01, 1'b0); // sum 254.
		for (int i = 0; i < RAND_PIXELS; i++)
		begin
			send_pixel(200 + 3 * i, next_random(), 1'b0);
			if (next_random() % 4 == 0)
				idle(1);
		end
		drain();
	endtask

	task automatic streaming();
		for (int i = 0; i < STREAM_PIXELS; i++)
		begin
			send_pixel(1000 + 7 * i, next_random(), 1'b0);
			stream_want[i] = exp_rgb[$];
		end
		drain();
		for (int i = 0; i < STREAM_PIXELS; i++)
			compare("stored pixel", mem_read(1000 + 7 * i), stream_want[i]);
	endtask

	task automatic frame_marker();
		send_pixel(3000, next_random(), 1'b0);
		send_pixel(3001, next_random(), 1'b1);
		idle(2);
		@(posedge clk);
		frame_ready <= 1'b1; // pulse with no pixel.
		idle(1);
		send_pixel(3002, next_random(), 1'b1);
		drain();
	endtask

	task automatic reset_mid_stream();
		for (int i = 0; i < 3; i++)
			send_pixel(5000 + i, next_random(), 1'b0);
		@(posedge clk);
		rst <= 1'b1;
		pixel_ready <= 1'b0;
		frame_ready <= 1'b0;
		exp_addr.delete(); // these never get written.
		exp_rgb.delete();
		exp_mark.delete();
		@(posedge clk);
		@(posedge clk);
		rst <= 1'b0;
		idle(4);
		for (int i = 0; i < 3; i++)
		begin
			if (mem.exists(5000 + i))
			begin
				$display("Pixel %0d was written although reset hit it in flight", 5000 + i);
				errors++;
			end
		end
		for (int i = 0; i < 4; i++)
			send_pixel(5010 + i, next_random(), 1'b0);
		drain();
	endtask

	initial
	begin
		while (cycle_count < MAX_CYCLES)
		begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Timeout after %0d cycles, pipeline did not drain", cycle_count);
		$display("FAIL: see errors above");
		$finish;
	end

	initial
	begin
		rst = 1'b1;
		pixel_ready = 1'b0;
		frame_ready = 1'b0;
		pixel_number = '0;
		r = '0;
		g = '0;
		b = '0;
		a = '0;
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		alpha_extremes();
		random_alpha();
		streaming();
		frame_marker();
		reset_mid_stream();
		$display("errors: %0d", errors);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire

// File: list.f
+incdir+include
logic/blend_pkg.sv
logic/pixel_fetch.sv
logic/alpha_weight.sv
logic/norm_divide.sv
logic/alpha_blender.sv
test/alpha_blender_chk.sv
test/alpha_blender_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= alpha_blender_tb
FILELIST ?= list.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --timing --assert
FAIL_TEXT = FAIL: see errors above

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_TEXT)" $(LOG); then exit 1; fi; exit $$status

clean:
	rm -rf $(BUILD_DIR) $(LOG)
